//--- hdl/cpuPkg.sv
`default_nettype none

package cpuPkg;

	// Datapath widths
	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [5:0] funct_t;
	typedef logic [4:0] shamt_t;
	typedef logic [5:0] opcode_t;

	// Supported opcodes
	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_ADDI = 6'h08;
	localparam opcode_t OP_SLTI = 6'h0A;
	localparam opcode_t OP_ANDI = 6'h0C;
	localparam opcode_t OP_ORI = 6'h0D;
	localparam opcode_t OP_XORI = 6'h0E;
	localparam opcode_t OP_LW = 6'h23;
	localparam opcode_t OP_SW = 6'h2B;

	// ALU operations, same encoding as the R-type funct field
	localparam funct_t FUNCT_SLL = 6'h00;
	localparam funct_t FUNCT_SRL = 6'h02;
	localparam funct_t FUNCT_SRA = 6'h03;
	localparam funct_t FUNCT_ADD = 6'h20;
	localparam funct_t FUNCT_SUB = 6'h22;
	localparam funct_t FUNCT_AND = 6'h24;
	localparam funct_t FUNCT_OR = 6'h25;
	localparam funct_t FUNCT_XOR = 6'h26;
	localparam funct_t FUNCT_SLT = 6'h2A;

	// Shared memory, 1 KB of words
	localparam int MEM_WORDS = 256;
	localparam int MEM_ADDR_BITS = 8;

	// Architectural registers
	localparam int REG_COUNT = 32;

endpackage

`default_nettype wire

//--- hdl/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fetchUnit
	import cpuPkg::*;
(
	input logic clk,
	input logic rst,
	input logic advance,
	output word_t pcAddress,
	output word_t fetchedPc
);

	word_t pc;

	// PC steps one word per advancing edge
	// fetchedPc trails by one to match the registered instruction read
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pc <= '0;
			fetchedPc <= '0;
		end else if (advance) begin
			fetchedPc <= pc;
			pc <= pc + 32'd4;
		end
	end

	assign pcAddress = pc;

	pcAlignCheck: assert property (
		@(posedge clk) disable iff (!rst)
		pcAddress[1:0] == 2'b00 && fetchedPc[1:0] == 2'b00
	) else $error("PC lost word alignment");

endmodule

`default_nettype wire

//--- hdl/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder
	import cpuPkg::*;
(
	input word_t instrData,
	output regAddr_t rsAddress,
	output regAddr_t rtAddress,
	output regAddr_t writeAddress,
	output logic regWrite,
	output logic useImmediate,
	output logic memRead,
	output logic memWrite,
	output funct_t funct,
	output shamt_t shamt,
	output word_t immediate
);

	opcode_t opcode;
	regAddr_t rdAddress;
	logic [15:0] rawImmediate;
	logic signExtend;
	logic writesRd;
	logic writesReg;

	// Instruction fields
	assign opcode = instrData[31:26];
	assign rsAddress = instrData[25:21];
	assign rtAddress = instrData[20:16];
	assign rdAddress = instrData[15:11];
	assign rawImmediate = instrData[15:0];

	// Defaults describe a sign-extended I-type ALU op writing rt
	always_comb begin
		funct = FUNCT_ADD;
		shamt = '0;
		useImmediate = 1'b1;
		signExtend = 1'b1;
		writesRd = 1'b0;
		writesReg = 1'b1;
		memRead = 1'b0;
		memWrite = 1'b0;
		case (opcode)
			OP_RTYPE: begin
				funct = instrData[5:0];
				shamt = instrData[10:6];
				useImmediate = 1'b0;
				writesRd = 1'b1;
			end
			OP_ADDI: funct = FUNCT_ADD;
			OP_SLTI: funct = FUNCT_SLT;
			OP_ANDI: begin
				funct = FUNCT_AND;
				signExtend = 1'b0;
			end
			OP_ORI: begin
				funct = FUNCT_OR;
				signExtend = 1'b0;
			end
			OP_XORI: begin
				funct = FUNCT_XOR;
				signExtend = 1'b0;
			end
			// Address is rs plus offset
			OP_LW: memRead = 1'b1;
			OP_SW: begin
				memWrite = 1'b1;
				writesReg = 1'b0;
			end
			default: writesReg = 1'b0;
		endcase
	end

	assign immediate = signExtend ? {{16{rawImmediate[15]}}, rawImmediate}
		: {16'd0, rawImmediate};
	assign writeAddress = writesRd ? rdAddress : rtAddress;

	// Register zero never takes a write
	assign regWrite = writesReg && (writeAddress != '0);

endmodule

`default_nettype wire

//--- hdl/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile
	import cpuPkg::*;
(
	input logic clk,
	input logic rst,
	input regAddr_t rsAddress,
	input regAddr_t rtAddress,
	input regAddr_t writeAddress,
	input logic writeEnable,
	input word_t writeData,
	output word_t readValue0,
	output word_t readValue1
);

	word_t regs [REG_COUNT];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable) begin
			regs[writeAddress] <= writeData;
		end
	end

	// Reads see a same-cycle write so writeback and decode can overlap
	assign readValue0 = (rsAddress == '0) ? '0
		: (writeEnable && writeAddress == rsAddress) ? writeData : regs[rsAddress];
	assign readValue1 = (rtAddress == '0) ? '0
		: (writeEnable && writeAddress == rtAddress) ? writeData : regs[rtAddress];

	zeroWriteCheck: assert property (
		@(posedge clk) disable iff (!rst)
		!(writeEnable && writeAddress == '0)
	) else $error("Write aimed at register zero reached the register file");

endmodule

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
	import cpuPkg::*;
(
	input word_t dataIn0,
	input word_t dataIn1,
	input funct_t funct,
	input shamt_t shamt,
	output word_t result
);

	logic lessThan;

	// Signed compare for SLT and SLTI
	assign lessThan = $signed(dataIn0) < $signed(dataIn1);

	always_comb begin
		case (funct)
			// Shifts act on the second operand, as in MIPS
			FUNCT_SLL: result = dataIn1 << shamt;
			FUNCT_SRL: result = dataIn1 >> shamt;
			FUNCT_SRA: result = word_t'($signed(dataIn1) >>> shamt);
			FUNCT_ADD: result = dataIn0 + dataIn1;
			FUNCT_SUB: result = dataIn0 - dataIn1;
			FUNCT_AND: result = dataIn0 & dataIn1;
			FUNCT_OR: result = dataIn0 | dataIn1;
			FUNCT_XOR: result = dataIn0 ^ dataIn1;
			FUNCT_SLT: result = {31'd0, lessThan};
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/memory.sv
`timescale 1ns/1ps
`default_nettype none

module memory
	import cpuPkg::*;
(
	input logic clk,
	input word_t instrAddress,
	output word_t instrData,
	input word_t dataAddress,
	input word_t dataIn,
	input logic dataWrite,
	output word_t dataOut
);

	word_t ram [MEM_WORDS];

	logic [MEM_ADDR_BITS-1:0] instrIndex;
	logic [MEM_ADDR_BITS-1:0] dataIndex;

	// Word index from the byte address
	assign instrIndex = instrAddress[MEM_ADDR_BITS+1:2];
	assign dataIndex = dataAddress[MEM_ADDR_BITS+1:2];

	// Both read ports registered; data read returns the old word on a write
	always_ff @(posedge clk) begin
		if (dataWrite) begin
			ram[dataIndex] <= dataIn;
		end
		dataOut <= ram[dataIndex];
		instrData <= ram[instrIndex];
	end

	// Core stores and external writes share this port
	dataWriteCheck: assert property (
		@(posedge clk)
		dataWrite |-> (dataAddress[1:0] == 2'b00 &&
			dataAddress[31:MEM_ADDR_BITS+2] == '0)
	) else $error("Misaligned or out of range write to %h", dataAddress);

endmodule

`default_nettype wire

//--- hdl/processor.sv
`timescale 1ns/1ps
`default_nettype none

module processor
	import cpuPkg::*;
(
	input logic clk,
	input logic rst,
	input logic pause,
	input logic externalMemoryControl,
	input word_t externalAddress,
	input word_t externalData,
	input logic externalWrite,
	output word_t externalDataOut
);

	logic advance;
	logic lastAdvance;
	word_t pcAddress, instrData, instrHold, decodeInstr;
	regAddr_t rsAddress, rtAddress, writeAddress;
	logic regWrite, useImmediate, memRead, memWrite;
	funct_t funct;
	shamt_t shamt;
	word_t immediate, readValue0, readValue1;

	// Execute, memory and writeback stage registers
	word_t exRsValue, exRtValue, exImmediate;
	funct_t exFunct;
	shamt_t exShamt;
	logic exUseImmediate, exRegWrite, exMemRead, exMemWrite;
	regAddr_t exWriteAddress;
	word_t aluOperand1, aluResult, memAluResult, memStoreData;
	logic memRegWrite, memMemRead, memMemWrite;
	regAddr_t memWriteAddress;
	word_t wbAluResult, loadHold, loadData, wbData;
	logic wbRegWrite, wbMemRead;
	regAddr_t wbWriteAddress;
	word_t dataAddress, dataIn, dataOut;
	logic dataWrite;

	assign advance = !pause;

	fetchUnit fetch_i (.clk(clk), .rst(rst), .advance(advance),
		.pcAddress(pcAddress), .fetchedPc());

	memory memory_i (.clk(clk), .instrAddress(pcAddress), .instrData(instrData),
		.dataAddress(dataAddress), .dataIn(dataIn), .dataWrite(dataWrite),
		.dataOut(dataOut));

	// Memory reads run even when paused, so hold the last fresh read words
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			lastAdvance <= 1'b0;
			instrHold <= '0;
		end else begin
			lastAdvance <= advance;
			if (lastAdvance) begin
				instrHold <= instrData;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (lastAdvance) begin
			loadHold <= dataOut;
		end
	end

	// Zero before the first fetch gives a no-op
	assign decodeInstr = lastAdvance ? instrData : instrHold;

	decoder decoder_i (.instrData(decodeInstr), .rsAddress(rsAddress),
		.rtAddress(rtAddress), .writeAddress(writeAddress), .regWrite(regWrite),
		.useImmediate(useImmediate), .memRead(memRead), .memWrite(memWrite),
		.funct(funct), .shamt(shamt), .immediate(immediate));

	registerFile registerFile_i (.clk(clk), .rst(rst), .rsAddress(rsAddress),
		.rtAddress(rtAddress), .writeAddress(wbWriteAddress),
		.writeEnable(wbRegWrite && advance), .writeData(wbData),
		.readValue0(readValue0), .readValue1(readValue1));

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			{exRegWrite, exMemRead, exMemWrite} <= '0;
			{memRegWrite, memMemRead, memMemWrite} <= '0;
			{wbRegWrite, wbMemRead} <= '0;
		end else if (advance) begin
			{exRegWrite, exMemRead, exMemWrite} <= {regWrite, memRead, memWrite};
			{memRegWrite, memMemRead, memMemWrite} <= {exRegWrite, exMemRead, exMemWrite};
			{wbRegWrite, wbMemRead} <= {memRegWrite, memMemRead};
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			exRsValue <= readValue0;
			exRtValue <= readValue1;
			exImmediate <= immediate;
			exFunct <= funct;
			exShamt <= shamt;
			exUseImmediate <= useImmediate;
			exWriteAddress <= writeAddress;
			memAluResult <= aluResult;
			memStoreData <= exRtValue;
			memWriteAddress <= exWriteAddress;
			wbAluResult <= memAluResult;
			wbWriteAddress <= memWriteAddress;
		end
	end

	assign aluOperand1 = exUseImmediate ? exImmediate : exRtValue;

	alu alu_i (.dataIn0(exRsValue), .dataIn1(aluOperand1), .funct(exFunct),
		.shamt(exShamt), .result(aluResult));

	// External access takes the data port; a core store in that cycle is dropped
	assign dataAddress = externalMemoryControl ? externalAddress : memAluResult;
	assign dataIn = externalMemoryControl ? externalData : memStoreData;
	assign dataWrite = externalMemoryControl ? externalWrite : (memMemWrite && advance);
	assign externalDataOut = externalMemoryControl ? dataOut : '0;

	assign loadData = lastAdvance ? dataOut : loadHold;
	assign wbData = wbMemRead ? loadData : wbAluResult;

endmodule

`default_nettype wire

//--- bench/processorTb.sv
`timescale 1ns/1ps
`default_nettype none

module processorTb
	import cpuPkg::*;
();

	localparam int RUN_CYCLES = 120;
	// Reset, memory fill, pause hold, run and readback of one test
	localparam int TEST_CYCLES = 3 + MEM_WORDS + 20 + RUN_CYCLES + 40;
	localparam int WATCHDOG_CYCLES = 2 * 5 * TEST_CYCLES;
	localparam word_t DATA_BASE = 32'h300;

	logic clk, rst, pause, externalMemoryControl, externalWrite;
	word_t externalAddress, externalData, externalDataOut;
	word_t prog[$], expAddr[$], expData[$];
	word_t modelRegs [REG_COUNT];
	integer seed = 34732;
	int errorCount = 0;

	processor processor_i (.clk(clk), .rst(rst), .pause(pause),
		.externalMemoryControl(externalMemoryControl), .externalAddress(externalAddress),
		.externalData(externalData), .externalWrite(externalWrite),
		.externalDataOut(externalDataOut));

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic checkWord(string name, word_t expected, word_t actual);
		if (actual !== expected) begin
			errorCount++;
			$display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	// One cycle on the data port; read data shows up one cycle after the address
	task automatic externalAccess(word_t addr, word_t data, logic write, output word_t got);
		externalMemoryControl = 1'b1;
		externalAddress = addr;
		externalData = data;
		externalWrite = write;
		tick();
		externalWrite = 1'b0;
		got = externalDataOut;
	endtask

	task automatic startTest();
		pause = 1'b1;
		externalMemoryControl = 1'b0;
		rst = 1'b0;
		repeat (3) tick();
		rst = 1'b1;
		prog.delete();
		expAddr.delete();
		expData.delete();
		modelRegs = '{default: '0};
	endtask

	// Program from word zero, no-ops up to the data area
	// Data words get their inverted address so a missing store shows
	task automatic loadProgram();
		word_t unused;
		word_t fill;
		for (int i = 0; i < MEM_WORDS; i++) begin
			if (i < prog.size()) begin
				fill = prog[i];
			end else if (word_t'(i * 4) >= DATA_BASE) begin
				fill = ~word_t'(i * 4);
			end else begin
				fill = '0;
			end
			externalAccess(word_t'(i * 4), fill, 1'b1, unused);
		end
	endtask

	task automatic runAndCheck();
		word_t got;
		externalMemoryControl = 1'b0;
		pause = 1'b0;
		repeat (RUN_CYCLES) tick();
		pause = 1'b1;
		for (int i = 0; i < expAddr.size(); i++) begin
			externalAccess(expAddr[i], '0, 1'b0, got);
			checkWord($sformatf("mem[%h]", expAddr[i]), expData[i], got);
		end
	endtask

	function automatic word_t aluModel(funct_t f, word_t a, word_t b, shamt_t sh);
		case (f)
			FUNCT_SLL: return b << sh;
			FUNCT_SRL: return b >> sh;
			// Sign bit copied into the vacated upper bits
			FUNCT_SRA: return (b >> sh) | (b[31] ? ~(32'hFFFF_FFFF >> sh) : 32'd0);
			FUNCT_ADD: return a + b;
			FUNCT_SUB: return a - b;
			FUNCT_AND: return a & b;
			FUNCT_OR: return a | b;
			FUNCT_XOR: return a ^ b;
			// Differing signs decide alone, equal signs compare as unsigned
			FUNCT_SLT: return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
			default: return '0;
		endcase
	endfunction

	// Two no-ops after each instruction, the core has no forwarding
	task automatic emit(word_t instr, regAddr_t dest, word_t value);
		prog.push_back(instr);
		prog.push_back('0);
		prog.push_back('0);
		if (dest != '0) begin
			modelRegs[dest] = value;
		end
	endtask

	task automatic opReg(funct_t f, regAddr_t rd, regAddr_t rs, regAddr_t rt, shamt_t sh);
		emit({OP_RTYPE, rs, rt, rd, sh, f}, rd, aluModel(f, modelRegs[rs], modelRegs[rt], sh));
	endtask

	task automatic opImm(opcode_t op, funct_t f, logic zeroExt, regAddr_t rt, regAddr_t rs,
		logic [15:0] imm);
		word_t ext;
		ext = zeroExt ? {16'd0, imm} : {{16{imm[15]}}, imm};
		emit({op, rs, rt, imm}, rt, aluModel(f, modelRegs[rs], ext, '0));
	endtask

	// Base register is r0, so the offset is the address
	task automatic opMem(opcode_t op, regAddr_t rt, word_t addr, word_t loaded);
		if (op == OP_SW) begin
			expAddr.push_back(addr);
			expData.push_back(modelRegs[rt]);
		end
		emit({op, 5'd0, rt, addr[15:0]}, (op == OP_LW) ? rt : 5'd0, loaded);
	endtask

	task automatic testExternalPort();
		word_t pattern;
		word_t got;
		startTest();
		for (int i = 0; i < 8; i++) begin
			pattern = $random(seed) ^ word_t'(DATA_BASE + i * 4);
			externalAccess(word_t'(DATA_BASE + i * 4), pattern, 1'b1, got);
			externalAccess(word_t'(DATA_BASE + i * 4), '0, 1'b0, got);
			checkWord($sformatf("external word %0d", i), pattern, got);
		end
		// Data port still holds the last word read, only control low hides it
		externalMemoryControl = 1'b0;
		#1;
		checkWord("externalDataOut", '0, externalDataOut);
	endtask

	task automatic testRegisterOps();
		funct_t ops [9];
		word_t r0, r1;
		ops = '{FUNCT_SLL, FUNCT_SRL, FUNCT_SRA, FUNCT_ADD, FUNCT_SUB, FUNCT_AND, FUNCT_OR,
			FUNCT_XOR, FUNCT_SLT};
		startTest();
		r0 = $random(seed);
		r1 = $random(seed);
		// Negative r1 makes SRA and SLT show their signed side
		opImm(OP_ADDI, FUNCT_ADD, 1'b0, 5'd1, 5'd0, r0[15:0] | 16'h8000);
		opImm(OP_ORI, FUNCT_OR, 1'b1, 5'd2, 5'd0, r1[15:0]);
		for (int i = 0; i < 9; i++) begin
			opReg(ops[i], 5'd3, 5'd2, 5'd1, r1[20:16]);
			opMem(OP_SW, 5'd3, word_t'(DATA_BASE + i * 4), '0);
		end
		opReg(FUNCT_SLT, 5'd4, 5'd1, 5'd2, 5'd0);
		opMem(OP_SW, 5'd4, DATA_BASE + 32'h40, '0);
		loadProgram();
		runAndCheck();
	endtask

	task automatic testImmediates();
		word_t r;
		startTest();
		r = $random(seed);
		opImm(OP_ADDI, FUNCT_ADD, 1'b0, 5'd1, 5'd0, r[15:0] | 16'h8000);
		opImm(OP_ORI, FUNCT_OR, 1'b1, 5'd2, 5'd0, r[31:16] & 16'h7FFF);
		r = $random(seed);
		opImm(OP_ADDI, FUNCT_ADD, 1'b0, 5'd5, 5'd2, r[15:0] | 16'h8000);
		opMem(OP_SW, 5'd5, DATA_BASE, '0);
		opImm(OP_SLTI, FUNCT_SLT, 1'b0, 5'd6, 5'd2, r[31:16] | 16'h8000);
		opMem(OP_SW, 5'd6, DATA_BASE + 32'h4, '0);
		r = $random(seed);
		// Zero extension clears or keeps the upper half of the negative r1
		opImm(OP_ANDI, FUNCT_AND, 1'b1, 5'd7, 5'd1, r[15:0] | 16'h8000);
		opMem(OP_SW, 5'd7, DATA_BASE + 32'h8, '0);
		opImm(OP_ORI, FUNCT_OR, 1'b1, 5'd8, 5'd2, r[31:16] | 16'h8000);
		opMem(OP_SW, 5'd8, DATA_BASE + 32'hC, '0);
		opImm(OP_XORI, FUNCT_XOR, 1'b1, 5'd9, 5'd1, r[23:8] | 16'h8000);
		opMem(OP_SW, 5'd9, DATA_BASE + 32'h10, '0);
		loadProgram();
		runAndCheck();
	endtask

	task automatic testLoads();
		word_t value, r, unused;
		startTest();
		value = $random(seed);
		r = $random(seed);
		opMem(OP_LW, 5'd4, DATA_BASE + 32'h80, value);
		opImm(OP_ADDI, FUNCT_ADD, 1'b0, 5'd5, 5'd4, r[15:0]);
		opMem(OP_SW, 5'd5, DATA_BASE + 32'h84, '0);
		loadProgram();
		externalAccess(DATA_BASE + 32'h80, value, 1'b1, unused);
		runAndCheck();
	endtask

	task automatic testZeroAndPause();
		word_t got;
		startTest();
		opImm(OP_ORI, FUNCT_OR, 1'b1, 5'd7, 5'd0, 16'hA5C3);
		opImm(OP_ADDI, FUNCT_ADD, 1'b0, 5'd0, 5'd7, 16'h1234);
		opReg(FUNCT_ADD, 5'd0, 5'd7, 5'd7, 5'd0);
		opMem(OP_SW, 5'd0, DATA_BASE + 32'hC0, '0);
		opMem(OP_SW, 5'd7, DATA_BASE + 32'hC4, '0);
		loadProgram();
		for (int i = 0; i < 2; i++) begin
			externalAccess(expAddr[i], ~expAddr[i], 1'b1, got);
		end
		// Port released but core still paused, so the targets keep their old words
		externalMemoryControl = 1'b0;
		repeat (20) tick();
		for (int i = 0; i < 2; i++) begin
			externalAccess(expAddr[i], '0, 1'b0, got);
			checkWord($sformatf("paused mem[%h]", expAddr[i]), ~expAddr[i], got);
		end
		runAndCheck();
	endtask

	initial begin
		rst = 1'b0;
		pause = 1'b1;
		externalMemoryControl = 1'b0;
		externalAddress = '0;
		externalData = '0;
		externalWrite = 1'b0;
		testExternalPort();
		testRegisterOps();
		testImmediates();
		testLoads();
		testZeroAndPause();
		$display("Tests done, errors: %0d", errorCount);
		if (errorCount == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
hdl/cpuPkg.sv
hdl/fetchUnit.sv
hdl/decoder.sv
hdl/registerFile.sv
hdl/alu.sv
hdl/memory.sv
hdl/processor.sv
bench/processorTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps --top-module processorTb \
	-f flist.f -o processorSim > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/processorSim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

grep -q "=== FAIL ===" sim.log && exit 1 || exit 0
